//--- Bender.yml
package:
  name: spi_master

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/spi_pkg.sv
      - verilog/spi_regs.sv
      - verilog/spi_shift_engine.sv
      - verilog/spi_top.sv
  - target: test
    files:
      - tests/spi_slave_model.sv
      - tests/tb_spi_top.sv

//--- tb.f
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_regs.sv
verilog/spi_shift_engine.sv
verilog/spi_top.sv
tests/spi_slave_model.sv
tests/tb_spi_top.sv

//--- tests/spi_slave_model.sv
`default_nettype none

`include "spi_defines.svh"

// Mode 0 slave that shifts MSB first on both lines
module spi_slave_model (
  input  logic                  ss_n,
  input  logic                  sclk,
  input  logic                  mosi,
  input  logic [`SPI_WIDTH-1:0] ret_word,
  output logic                  miso,
  output logic [`SPI_WIDTH-1:0] got_word
);

  logic [`SPI_WIDTH-1:0] out_sr = '0;
  logic [`SPI_WIDTH-1:0] in_sr  = '0;

  initial begin
    miso     = 1'b0;
    got_word = '0;
  end

  // First bit has to be on miso before the first rising sclk
  always @(negedge ss_n) begin
    out_sr = ret_word;
    miso   = ret_word[`SPI_WIDTH-1];
    in_sr  = '0;
  end

  always @(negedge sclk) begin
    if (ss_n === 1'b0) begin
      out_sr = {out_sr[`SPI_WIDTH-2:0], 1'b0};
      miso   = out_sr[`SPI_WIDTH-1];
    end
  end

  always @(posedge sclk) begin
    if (ss_n === 1'b0) begin
      in_sr = {in_sr[`SPI_WIDTH-2:0], mosi};
    end
  end

  // Received word only becomes visible at the end of the frame
  always @(posedge ss_n) begin
    got_word = in_sr;
  end

endmodule

`default_nettype wire

//--- tests/tb_spi_top.sv
`default_nettype none

`include "spi_defines.svh"

module tb_spi_top;

  import spi_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_XFERS   = 12;
  localparam int MAX_DIV     = 7;
  localparam int XFER_CYCLES = 2 * `SPI_WIDTH * (MAX_DIV + 1) + 3;
  localparam int WATCHDOG    = 2 * (NUM_XFERS + 1) * XFER_CYCLES + 100;

  logic                      clk;
  logic                      rst_n;
  logic                      reg_wr;
  logic                      reg_rd;
  logic [1:0]                reg_addr;
  spi_wword_t                reg_wdata;
  logic [`SPI_BUS_WIDTH-1:0] reg_rdata;
  logic                      irq;
  logic                      sclk;
  logic                      mosi;
  logic                      miso;
  logic                      ss_n;
  logic [`SPI_WIDTH-1:0]     ret_word;
  logic [`SPI_WIDTH-1:0]     got_word;

  logic [31:0] seed;
  int          cur_div;
  time         last_edge;

  spi_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .irq       (irq),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso),
    .ss_n      (ss_n)
  );

  spi_slave_model i_slave (
    .ss_n     (ss_n),
    .sclk     (sclk),
    .mosi     (mosi),
    .ret_word (ret_word),
    .miso     (miso),
    .got_word (got_word)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Watchdog expired before all tests completed");
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word as seen MSB first on the wire
  function automatic logic [`SPI_WIDTH-1:0] apply_bit_order(input logic [`SPI_WIDTH-1:0] w,
                                                            input logic lsb);
    logic [`SPI_WIDTH-1:0] r;
    for (int i = 0; i < `SPI_WIDTH; i++) begin
      r[i] = w[`SPI_WIDTH-1-i];
    end
    return lsb ? r : w;
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
    $display("TESTS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [`SPI_BUS_WIDTH-1:0] data);
    @(negedge clk);
    reg_wr         = 1'b1;
    reg_addr       = addr;
    reg_wdata.data = data;
    @(posedge clk);
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] addr, output logic [`SPI_BUS_WIDTH-1:0] data);
    @(negedge clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge clk);
    data = reg_rdata;
    @(negedge clk);
    reg_rd = 1'b0;
  endtask

  // Counts clocks until ss_n has fallen and risen again
  task automatic wait_frame_end(output int cycles);
    logic seen_low;
    seen_low = 1'b0;
    cycles   = 0;
    while (!(seen_low && ss_n === 1'b1)) begin
      @(posedge clk);
      cycles++;
      if (ss_n === 1'b0) begin
        seen_low = 1'b1;
      end
      if (cycles > XFER_CYCLES + 20) begin
        abort_run("Timed out waiting for the SPI frame to end");
      end
    end
  endtask

  task automatic run_transfer(input logic [`SPI_WIDTH-1:0] tx, input logic [`SPI_WIDTH-1:0] ret,
                              input logic [7:0] div, input logic lsb);
    spi_cfg_t                  cfg;
    logic [`SPI_BUS_WIDTH-1:0] rd;
    int                        cycles;
    int                        exp_cycles;
    cfg           = '0;
    cfg.clk_div   = div;
    cfg.lsb_first = lsb;
    exp_cycles    = 2 * `SPI_WIDTH * (div + 1) + 3;
    write_reg(REG_CFG, cfg);
    cur_div  = div;
    ret_word = ret;
    write_reg(REG_TX, tx);
    wait_frame_end(cycles);
    assert (cycles == exp_cycles) else flag_mismatch("done latency", cycles, exp_cycles);
    @(posedge clk);
    assert (irq === 1'b1) else flag_mismatch("irq", irq, 1);
    assert (got_word === apply_bit_order(tx, lsb))
      else flag_mismatch("got_word", got_word, apply_bit_order(tx, lsb));
    read_reg(REG_RX, rd);
    assert (rd === apply_bit_order(ret, lsb))
      else flag_mismatch("RX", rd, apply_bit_order(ret, lsb));
    read_reg(REG_STATUS, rd);
    assert (rd === 16'h0002) else flag_mismatch("STATUS", rd, 16'h0002);
    assert (irq === 1'b1) else flag_mismatch("irq", irq, 1);
    // Clearing done drops irq
    write_reg(REG_STATUS, 16'h0002);
    @(posedge clk);
    assert (irq === 1'b0) else flag_mismatch("irq", irq, 0);
  endtask

  //////////////////////////////
  // Pin monitors
  //////////////////////////////

  always @(negedge ss_n) begin
    last_edge = $time;
  end

  // Every sclk phase including the first low one
  always @(sclk) begin
    if (rst_n === 1'b1 && ss_n === 1'b0) begin
      assert ($time - last_edge == (cur_div + 1) * CLK_PERIOD)
        else flag_mismatch("sclk phase", $time - last_edge, (cur_div + 1) * CLK_PERIOD);
      last_edge = $time;
    end
  end

  a_mosi_idle: assert property (@(posedge clk) disable iff (!rst_n)
    ss_n |-> !mosi) else flag_mismatch("mosi", mosi, 0);

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    spi_cfg_t                  cfg;
    logic [`SPI_BUS_WIDTH-1:0] rd;
    logic [`SPI_WIDTH-1:0]     word_a;
    int                        cycles;

    rst_n     = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    ret_word  = '0;
    seed      = 32'hf56929af;
    cur_div   = 0;
    last_edge = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle pins and cleared registers
    @(posedge clk);
    assert (ss_n === 1'b1) else flag_mismatch("ss_n", ss_n, 1);
    assert (sclk === 1'b0) else flag_mismatch("sclk", sclk, 0);
    assert (mosi === 1'b0) else flag_mismatch("mosi", mosi, 0);
    assert (irq === 1'b0) else flag_mismatch("irq", irq, 0);
    read_reg(REG_STATUS, rd);
    assert (rd === '0) else flag_mismatch("STATUS", rd, 0);
    read_reg(REG_CFG, rd);
    assert (rd === '0) else flag_mismatch("CFG", rd, 0);
    read_reg(REG_RX, rd);
    assert (rd === '0) else flag_mismatch("RX", rd, 0);

    for (int i = 0; i < 4; i++) begin
      seed          = lcg_next(seed);
      cfg           = '0;
      cfg.clk_div   = seed[31:24];
      cfg.lsb_first = i[0];
      write_reg(REG_CFG, cfg);
      read_reg(REG_CFG, rd);
      assert (rd === cfg) else flag_mismatch("CFG", rd, cfg);
    end

    // Random words on small dividers
    for (int i = 0; i < NUM_XFERS; i++) begin
      seed = lcg_next(seed);
      run_transfer(seed[31:24], seed[23:16], (i == 0) ? 8'd0 : {5'd0, seed[15:13]}, i[0]);
    end

    // Second TX write lands while the first frame runs
    seed        = lcg_next(seed);
    word_a      = seed[31:24];
    cfg         = '0;
    cfg.clk_div = 8'd3;
    write_reg(REG_CFG, cfg);
    cur_div  = 3;
    ret_word = seed[23:16];
    write_reg(REG_TX, word_a);
    write_reg(REG_TX, ~word_a);
    read_reg(REG_STATUS, rd);
    assert (rd === 16'h0005) else flag_mismatch("STATUS", rd, 16'h0005);
    wait_frame_end(cycles);
    assert (got_word === word_a) else flag_mismatch("got_word", got_word, word_a);
    read_reg(REG_STATUS, rd);
    assert (rd === 16'h0006) else flag_mismatch("STATUS", rd, 16'h0006);
    write_reg(REG_STATUS, 16'h0004);
    read_reg(REG_STATUS, rd);
    assert (rd === 16'h0002) else flag_mismatch("STATUS", rd, 16'h0002);
    assert (irq === 1'b1) else flag_mismatch("irq", irq, 1);
    write_reg(REG_STATUS, 16'h0002);
    read_reg(REG_STATUS, rd);
    assert (rd === '0) else flag_mismatch("STATUS", rd, 0);
    assert (irq === 1'b0) else flag_mismatch("irq", irq, 0);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/spi_defines.svh
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Bits moved per transfer
`define SPI_WIDTH 8

// Register bus data width
`define SPI_BUS_WIDTH 16

// Register address codes
`define SPI_ADDR_CFG    2'd0
`define SPI_ADDR_TX     2'd1
`define SPI_ADDR_RX     2'd2
`define SPI_ADDR_STATUS 2'd3

`endif

//--- verilog/spi_pkg.sv
`default_nettype none

`include "spi_defines.svh"

package spi_pkg;

  // Configuration word with clk_div in the low byte
  typedef struct packed {
    logic [6:0] reserved;
    logic       lsb_first;
    logic [7:0] clk_div;
  } spi_cfg_t;

  // One bus write word seen as config fields or as plain data
  typedef union packed {
    spi_cfg_t                  cfg;
    logic [`SPI_BUS_WIDTH-1:0] data;
  } spi_wword_t;

  typedef enum logic [1:0] {
    REG_CFG    = `SPI_ADDR_CFG,
    REG_TX     = `SPI_ADDR_TX,
    REG_RX     = `SPI_ADDR_RX,
    REG_STATUS = `SPI_ADDR_STATUS
  } spi_addr_e;

endpackage

`default_nettype wire

//--- verilog/spi_regs.sv
`default_nettype none

`include "spi_defines.svh"

module spi_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      reg_wr,
  input  logic                      reg_rd,
  input  logic [1:0]                reg_addr,
  input  spi_pkg::spi_wword_t       reg_wdata,
  input  logic                      busy,
  input  logic                      done,
  input  logic [`SPI_WIDTH-1:0]     rx_word,
  output logic [`SPI_BUS_WIDTH-1:0] reg_rdata,
  output logic                      start,
  output logic [`SPI_WIDTH-1:0]     tx_word,
  output logic [7:0]                clk_div,
  output logic                      lsb_first,
  output logic                      irq
);

  import spi_pkg::*;

  spi_addr_e             addr;
  spi_cfg_t              cfg_q;
  logic [`SPI_WIDTH-1:0] rx_q;
  logic                  done_f;
  logic                  ovr_f;
  logic                  wr_cfg;
  logic                  wr_tx;
  logic                  wr_status;
  logic                  engine_active;

  assign addr      = spi_addr_e'(reg_addr);
  assign wr_cfg    = reg_wr && (addr == REG_CFG);
  assign wr_tx     = reg_wr && (addr == REG_TX);
  assign wr_status = reg_wr && (addr == REG_STATUS);

  // A pending start counts as busy too
  assign engine_active = busy || start;

  assign clk_div   = cfg_q.clk_div;
  assign lsb_first = cfg_q.lsb_first;
  assign irq       = done_f;

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q   <= '0;
      tx_word <= '0;
      rx_q    <= '0;
      start   <= 1'b0;
      done_f  <= 1'b0;
      ovr_f   <= 1'b0;
    end else begin
      start <= 1'b0;

      if (wr_cfg) begin
        cfg_q <= reg_wdata.cfg;
      end

      // Refused TX writes only leave a trace in overrun
      if (wr_tx && !engine_active) begin
        tx_word <= reg_wdata.data[`SPI_WIDTH-1:0];
        start   <= 1'b1;
      end

      if (done) begin
        rx_q <= rx_word;
      end

      // Set beats clear so no event is lost
      if (done) begin
        done_f <= 1'b1;
      end else if (wr_status && reg_wdata.data[1]) begin
        done_f <= 1'b0;
      end

      if (wr_tx && engine_active) begin
        ovr_f <= 1'b1;
      end else if (wr_status && reg_wdata.data[2]) begin
        ovr_f <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  always_comb begin
    reg_rdata = '0;
    if (reg_rd) begin
      case (addr)
        REG_CFG:    reg_rdata = cfg_q;
        REG_TX:     reg_rdata[`SPI_WIDTH-1:0] = tx_word;
        REG_RX:     reg_rdata[`SPI_WIDTH-1:0] = rx_q;
        REG_STATUS: reg_rdata[2:0] = {ovr_f, done_f, engine_active};
        default:    reg_rdata = '0;
      endcase
    end
  end

  // Engine must be idle whenever a start goes out
  a_start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy);

  a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> !start);

endmodule

`default_nettype wire

//--- verilog/spi_shift_engine.sv
`default_nettype none

`include "spi_defines.svh"

module spi_shift_engine (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [`SPI_WIDTH-1:0] tx_word,
  input  logic [7:0]            clk_div,
  input  logic                  lsb_first,
  input  logic                  miso,
  output logic                  busy,
  output logic                  done,
  output logic [`SPI_WIDTH-1:0] rx_word,
  output logic                  sclk,
  output logic                  mosi,
  output logic                  ss_n
);

  localparam int BIT_CNT_W = $clog2(`SPI_WIDTH);

  typedef enum logic [1:0] {IDLE, SHIFT, FINISH} state_e;

  state_e                state;
  logic [7:0]            div_cnt;
  logic [7:0]            div_q;
  logic                  lsb_q;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [`SPI_WIDTH-1:0] tx_sr;
  logic [`SPI_WIDTH-1:0] rx_sr;
  logic [`SPI_WIDTH-1:0] tx_next;
  logic                  half_end;
  logic                  last_bit;

  // End of one sclk half period
  assign half_end = (div_cnt == div_q);
  assign last_bit = (bit_cnt == BIT_CNT_W'(`SPI_WIDTH - 1));
  assign tx_next  = lsb_q ? (tx_sr >> 1) : (tx_sr << 1);

  //////////////////////////////
  // Control FSM and pins
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      busy    <= 1'b0;
      done    <= 1'b0;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      ss_n    <= 1'b1;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            state   <= SHIFT;
            div_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b1;
            ss_n    <= 1'b0;
            // First bit must be on mosi before the first rising edge
            mosi    <= lsb_first ? tx_word[0] : tx_word[`SPI_WIDTH-1];
          end
        end
        SHIFT: begin
          if (half_end) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            // Falling edge moves to the next bit
            if (sclk) begin
              if (last_bit) begin
                state <= FINISH;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
                mosi    <= lsb_q ? tx_next[0] : tx_next[`SPI_WIDTH-1];
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        FINISH: begin
          state <= IDLE;
          busy  <= 1'b0;
          done  <= 1'b1;
          ss_n  <= 1'b1;
          mosi  <= 1'b0;
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Data path
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      tx_sr <= tx_word;
      div_q <= clk_div;
      lsb_q <= lsb_first;
    end
    if (state == SHIFT && half_end) begin
      // Sample on the rising edge, shift on the falling one
      if (!sclk) begin
        rx_sr <= lsb_q ? {miso, rx_sr[`SPI_WIDTH-1:1]} : {rx_sr[`SPI_WIDTH-2:0], miso};
      end else begin
        tx_sr <= tx_next;
      end
    end
    if (state == FINISH) begin
      rx_word <= rx_sr;
    end
  end

  a_ss_busy: assert property (@(posedge clk) disable iff (!rst_n)
    ss_n == !busy);

  // Clock stays parked low outside a frame
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    ss_n |-> !sclk);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done);

endmodule

`default_nettype wire

//--- verilog/spi_top.sv
`default_nettype none

`include "spi_defines.svh"

module spi_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      reg_wr,
  input  logic                      reg_rd,
  input  logic [1:0]                reg_addr,
  input  spi_pkg::spi_wword_t       reg_wdata,
  output logic [`SPI_BUS_WIDTH-1:0] reg_rdata,
  output logic                      irq,
  output logic                      sclk,
  output logic                      mosi,
  input  logic                      miso,
  output logic                      ss_n
);

  // Register block to engine
  logic                  start;
  logic [`SPI_WIDTH-1:0] tx_word;
  logic [7:0]            clk_div;
  logic                  lsb_first;

  // Engine back to register block
  logic                  busy;
  logic                  done;
  logic [`SPI_WIDTH-1:0] rx_word;

  spi_regs i_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .busy      (busy),
    .done      (done),
    .rx_word   (rx_word),
    .reg_rdata (reg_rdata),
    .start     (start),
    .tx_word   (tx_word),
    .clk_div   (clk_div),
    .lsb_first (lsb_first),
    .irq       (irq)
  );

  spi_shift_engine i_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .tx_word   (tx_word),
    .clk_div   (clk_div),
    .lsb_first (lsb_first),
    .miso      (miso),
    .busy      (busy),
    .done      (done),
    .rx_word   (rx_word),
    .sclk      (sclk),
    .mosi      (mosi),
    .ss_n      (ss_n)
  );

endmodule

`default_nettype wire
